// ==== hdl/mem_msg_pkg.sv ====
// Memory message definitions shared by requester and memory model
// Op codes and field widths of the request and response

`default_nettype none

package mem_msg_pkg;

  // ----------------------------------------
  // Op codes
  // ----------------------------------------

  // One bit is enough for the two ops
  typedef enum logic {
    MEM_MSG_READ  = 1'b0,
    MEM_MSG_WRITE = 1'b1
  } mem_op_t;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------

  localparam int mem_addr_bits = 32;
  localparam int mem_data_bits = 32;

  // Byte count, zero stands for a full word
  localparam int mem_len_bits  = 4;

endpackage

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
// Fetch stage constants
// Reset address, instruction width, address step

`default_nettype none

package fetch_pkg;

  // ----------------------------------------
  // Fetch address stream
  // ----------------------------------------

  // First address after reset
  localparam logic [31:0] fetch_rst_addr = 32'h200;

  // Bytes between consecutive fetches
  localparam int fetch_step = 4;

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------

  localparam int inst_bits = 32;

endpackage

`default_nettype wire

// ==== hdl/seq_num_gen.sv ====
// Sequence number allocator
// Hands out numbers in order, reclaims oldest ones on commit pulses

`default_nettype none
`timescale 1ns/1ps

module seq_num_gen #(
  parameter int seq_num_bits  = 3,
  parameter int reclaim_width = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // Allocation handshake
  input  logic                     alloc_rdy,
  output logic                     alloc_val,
  output logic [seq_num_bits-1:0]  alloc_seq_num,

  // One pulse per retired instruction, lane 0 first
  input  logic [reclaim_width-1:0] commit_val
);

  // Total numbers available, one bit wider than a number
  localparam logic [seq_num_bits:0] num_seq = {1'b1, {seq_num_bits{1'b0}}};

  logic                     alloc_xfer;
  logic [seq_num_bits-1:0]  head;
  logic [seq_num_bits:0]    count;
  logic [seq_num_bits:0]    count_plus;
  logic [seq_num_bits:0]    count_next;
  logic [seq_num_bits:0]    commit_cnt;
  logic [reclaim_width-1:0] commit_inc;

  // ----------------------------------------
  // Allocation side
  // ----------------------------------------

  // Free while anything is left
  assign alloc_val     = (count < num_seq);
  assign alloc_seq_num = head;
  assign alloc_xfer    = alloc_val & alloc_rdy;

  // Head wraps at the number width
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (alloc_xfer) begin
      head <= head + 1'b1;
    end
  end

  // ----------------------------------------
  // Reclaim side
  // ----------------------------------------

  // Number of set commit lanes
  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < reclaim_width; i++) begin
      commit_cnt = commit_cnt + {{seq_num_bits{1'b0}}, commit_val[i]};
    end
  end

  // Oldest numbers go first, so a count is all that is needed
  assign count_plus = count + {{seq_num_bits{1'b0}}, alloc_xfer};
  assign count_next = count_plus - commit_cnt;

  // Freed slots usable the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Used for the lane contiguity check
  assign commit_inc = commit_val + 1'b1;

  // Commit side never retires more than is outstanding
  a_no_underflow : assert property (
    @(posedge clk) disable iff (rst)
    commit_cnt <= count_plus
  ) else $error("seq_num_gen: commit count exceeds outstanding numbers");

  // Lanes fill from lane 0 upward with no gaps
  a_lanes_contig : assert property (
    @(posedge clk) disable iff (rst)
    (commit_inc & commit_val) == '0
  ) else $error("seq_num_gen: commit lanes not contiguous from lane 0");

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
// Fetch unit front end
// Sequential read requests with an in-flight limit
// Responses joined with sequence numbers and passed to decode

`default_nettype none
`timescale 1ns/1ps

module fetch_unit
  import mem_msg_pkg::*, fetch_pkg::*;
#(
  parameter int opaq_bits    = 2,
  parameter int seq_num_bits = 3
) (
  input  logic                     clk,
  input  logic                     rst,

  // Memory request
  output logic                     mem_req_val,
  output mem_op_t                  mem_req_op,
  output logic [mem_addr_bits-1:0] mem_req_addr,
  output logic [opaq_bits-1:0]     mem_req_opaque,
  output logic [mem_len_bits-1:0]  mem_req_len,
  output logic [mem_data_bits-1:0] mem_req_data,
  input  logic                     mem_req_rdy,

  // Memory response
  input  logic                     mem_resp_val,
  input  mem_op_t                  mem_resp_op,
  input  logic [mem_addr_bits-1:0] mem_resp_addr,
  input  logic [opaq_bits-1:0]     mem_resp_opaque,
  input  logic [mem_len_bits-1:0]  mem_resp_len,
  input  logic [mem_data_bits-1:0] mem_resp_data,
  output logic                     mem_resp_rdy,

  // Decode
  output logic                     d_val,
  output logic [mem_addr_bits-1:0] d_pc,
  output logic [inst_bits-1:0]     d_inst,
  output logic [seq_num_bits-1:0]  d_seq_num,
  input  logic                     d_rdy,

  // Sequence number allocator
  input  logic                     alloc_val,
  input  logic [seq_num_bits-1:0]  alloc_seq_num,
  output logic                     alloc_rdy
);

  // Limit on outstanding requests
  localparam logic [opaq_bits:0] max_in_flight = {1'b1, {opaq_bits{1'b0}}};

  logic                     memreq_xfer;
  logic                     memresp_xfer;
  logic [opaq_bits:0]       in_flight;
  logic [opaq_bits:0]       in_flight_next;
  logic [mem_addr_bits-1:0] curr_addr;

  assign memreq_xfer  = mem_req_val & mem_req_rdy;
  assign memresp_xfer = mem_resp_val & mem_resp_rdy;

  // ----------------------------------------
  // In-flight tracking
  // ----------------------------------------

  // Both transfers in one cycle cancel out
  always_comb begin
    in_flight_next = in_flight;
    if (memreq_xfer && !memresp_xfer) begin
      in_flight_next = in_flight + 1'b1;
    end
    if (memresp_xfer && !memreq_xfer) begin
      in_flight_next = in_flight - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight_next;
    end
  end

  // ----------------------------------------
  // Request address
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= fetch_rst_addr;
    end else if (memreq_xfer) begin
      curr_addr <= curr_addr + mem_addr_bits'(fetch_step);
    end
  end

  // Always full-word reads with opaque 0
  assign mem_req_val    = (in_flight < max_in_flight);
  assign mem_req_op     = MEM_MSG_READ;
  assign mem_req_addr   = curr_addr;
  assign mem_req_opaque = '0;
  assign mem_req_len    = '0;
  assign mem_req_data   = '0;

  // ----------------------------------------
  // Response to decode
  // ----------------------------------------

  // Straight through with no added latency
  assign mem_resp_rdy = d_rdy & alloc_val;
  assign d_val        = mem_resp_val & alloc_val;
  assign d_pc         = mem_resp_addr;
  assign d_inst       = mem_resp_data;
  assign d_seq_num    = alloc_seq_num;

  // Allocation coincides with the decode transfer
  assign alloc_rdy    = d_rdy & mem_resp_val;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A response needs an earlier request
  a_in_flight_min : assert property (
    @(posedge clk) disable iff (rst)
    memresp_xfer |-> (in_flight != '0)
  ) else $error("fetch_unit: response with nothing in flight");

  // Memory answers with what was asked for
  a_resp_read : assert property (
    @(posedge clk) disable iff (rst)
    mem_resp_val |-> (mem_resp_op == MEM_MSG_READ) && (mem_resp_len == '0) &&
                     (mem_resp_opaque == '0)
  ) else $error("fetch_unit: unexpected response op, length or opaque");

endmodule

`default_nettype wire

// ==== hdl/inst_mem.sv ====
// Instruction memory model
// 64-word ROM, fixed latency pipeline, response FIFO with back-pressure

`default_nettype none
`timescale 1ns/1ps

module inst_mem
  import mem_msg_pkg::*;
#(
  parameter int opaq_bits   = 2,
  parameter int mem_latency = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // Request
  input  logic                     mem_req_val,
  input  mem_op_t                  mem_req_op,
  input  logic [mem_addr_bits-1:0] mem_req_addr,
  input  logic [opaq_bits-1:0]     mem_req_opaque,
  input  logic [mem_len_bits-1:0]  mem_req_len,
  input  logic [mem_data_bits-1:0] mem_req_data,
  output logic                     mem_req_rdy,

  // Response
  output logic                     mem_resp_val,
  output mem_op_t                  mem_resp_op,
  output logic [mem_addr_bits-1:0] mem_resp_addr,
  output logic [opaq_bits-1:0]     mem_resp_opaque,
  output logic [mem_len_bits-1:0]  mem_resp_len,
  output logic [mem_data_bits-1:0] mem_resp_data,
  input  logic                     mem_resp_rdy
);

  localparam logic [opaq_bits:0] depth = {1'b1, {opaq_bits{1'b0}}};

  logic                     req_xfer;
  logic                     resp_xfer;
  logic                     fifo_wr;
  logic [opaq_bits:0]       occupancy;
  logic [opaq_bits:0]       fifo_cnt;
  logic [opaq_bits-1:0]     wr_ptr;
  logic [opaq_bits-1:0]     rd_ptr;

  // Word array, addresses wrap every 256 bytes
  logic [mem_data_bits-1:0] rom [64];

  // Delay line stages
  logic                     pipe_val    [mem_latency];
  logic [mem_data_bits-1:0] pipe_data   [mem_latency];
  logic [mem_addr_bits-1:0] pipe_addr   [mem_latency];
  logic [opaq_bits-1:0]     pipe_opaque [mem_latency];

  // Response queue storage
  logic [mem_data_bits-1:0] fifo_data   [1 << opaq_bits];
  logic [mem_addr_bits-1:0] fifo_addr   [1 << opaq_bits];
  logic [opaq_bits-1:0]     fifo_opaque [1 << opaq_bits];

  initial begin
    $readmemh("hdl/inst_rom.hex", rom);
  end

  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;
  assign fifo_wr   = pipe_val[mem_latency-1];

  // ----------------------------------------
  // Credit count over pipeline and FIFO
  // ----------------------------------------

  // No accept unless a queue slot is guaranteed
  assign mem_req_rdy = (occupancy < depth);

  always_ff @(posedge clk) begin
    if (rst) begin
      occupancy <= '0;
    end else if (req_xfer && !resp_xfer) begin
      occupancy <= occupancy + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      occupancy <= occupancy - 1'b1;
    end
  end

  // ----------------------------------------
  // Latency pipeline
  // ----------------------------------------

  // Valid bits cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < mem_latency; i++) begin
        pipe_val[i] <= 1'b0;
      end
    end else begin
      pipe_val[0] <= req_xfer;
      for (int i = 1; i < mem_latency; i++) begin
        pipe_val[i] <= pipe_val[i-1];
      end
    end
  end

  // Payload, ROM read at request time
  always_ff @(posedge clk) begin
    pipe_data[0]   <= rom[mem_req_addr[7:2]];
    pipe_addr[0]   <= mem_req_addr;
    pipe_opaque[0] <= mem_req_opaque;
    for (int i = 1; i < mem_latency; i++) begin
      pipe_data[i]   <= pipe_data[i-1];
      pipe_addr[i]   <= pipe_addr[i-1];
      pipe_opaque[i] <= pipe_opaque[i-1];
    end
  end

  // ----------------------------------------
  // Response FIFO
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (resp_xfer) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (fifo_wr && !resp_xfer) begin
        fifo_cnt <= fifo_cnt + 1'b1;
      end else if (resp_xfer && !fifo_wr) begin
        fifo_cnt <= fifo_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_wr) begin
      fifo_data[wr_ptr]   <= pipe_data[mem_latency-1];
      fifo_addr[wr_ptr]   <= pipe_addr[mem_latency-1];
      fifo_opaque[wr_ptr] <= pipe_opaque[mem_latency-1];
    end
  end

  // Head of queue, held until taken
  assign mem_resp_val    = (fifo_cnt != '0);
  assign mem_resp_op     = MEM_MSG_READ;
  assign mem_resp_addr   = fifo_addr[rd_ptr];
  assign mem_resp_opaque = fifo_opaque[rd_ptr];
  assign mem_resp_len    = '0;
  assign mem_resp_data   = fifo_data[rd_ptr];

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Credits must keep the queue from overflowing
  a_fifo_overflow : assert property (
    @(posedge clk) disable iff (rst)
    (fifo_wr && !resp_xfer) |-> (fifo_cnt < depth)
  ) else $error("inst_mem: response FIFO overflow");

  // Only clean full-word reads are modeled
  a_req_read : assert property (
    @(posedge clk) disable iff (rst)
    mem_req_val |-> (mem_req_op == MEM_MSG_READ) && (mem_req_len == '0) &&
                    !$isunknown(mem_req_data)
  ) else $error("inst_mem: request is not a full-word read");

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
// Fetch top level
// Fetch unit, sequence number allocator and instruction memory

`default_nettype none
`timescale 1ns/1ps

module fetch_top
  import mem_msg_pkg::*, fetch_pkg::*;
#(
  parameter int opaq_bits     = 2,
  parameter int seq_num_bits  = 3,
  parameter int reclaim_width = 2,
  parameter int mem_latency   = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // Decode
  output logic                     d_val,
  output logic [mem_addr_bits-1:0] d_pc,
  output logic [inst_bits-1:0]     d_inst,
  output logic [seq_num_bits-1:0]  d_seq_num,
  input  logic                     d_rdy,

  // Commit pulses
  input  logic [reclaim_width-1:0] commit_val
);

  // ----------------------------------------
  // Memory request and response
  // ----------------------------------------

  logic                     mem_req_val;
  mem_op_t                  mem_req_op;
  logic [mem_addr_bits-1:0] mem_req_addr;
  logic [opaq_bits-1:0]     mem_req_opaque;
  logic [mem_len_bits-1:0]  mem_req_len;
  logic [mem_data_bits-1:0] mem_req_data;
  logic                     mem_req_rdy;

  logic                     mem_resp_val;
  mem_op_t                  mem_resp_op;
  logic [mem_addr_bits-1:0] mem_resp_addr;
  logic [opaq_bits-1:0]     mem_resp_opaque;
  logic [mem_len_bits-1:0]  mem_resp_len;
  logic [mem_data_bits-1:0] mem_resp_data;
  logic                     mem_resp_rdy;

  // Allocator link
  logic                     alloc_val;
  logic [seq_num_bits-1:0]  alloc_seq_num;
  logic                     alloc_rdy;

  fetch_unit #(
    .opaq_bits    (opaq_bits),
    .seq_num_bits (seq_num_bits)
  ) u_fetch_unit (
    .clk             (clk),
    .rst             (rst),
    .mem_req_val     (mem_req_val),
    .mem_req_op      (mem_req_op),
    .mem_req_addr    (mem_req_addr),
    .mem_req_opaque  (mem_req_opaque),
    .mem_req_len     (mem_req_len),
    .mem_req_data    (mem_req_data),
    .mem_req_rdy     (mem_req_rdy),
    .mem_resp_val    (mem_resp_val),
    .mem_resp_op     (mem_resp_op),
    .mem_resp_addr   (mem_resp_addr),
    .mem_resp_opaque (mem_resp_opaque),
    .mem_resp_len    (mem_resp_len),
    .mem_resp_data   (mem_resp_data),
    .mem_resp_rdy    (mem_resp_rdy),
    .d_val           (d_val),
    .d_pc            (d_pc),
    .d_inst          (d_inst),
    .d_seq_num       (d_seq_num),
    .d_rdy           (d_rdy),
    .alloc_val       (alloc_val),
    .alloc_seq_num   (alloc_seq_num),
    .alloc_rdy       (alloc_rdy)
  );

  seq_num_gen #(
    .seq_num_bits  (seq_num_bits),
    .reclaim_width (reclaim_width)
  ) u_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .alloc_rdy     (alloc_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .commit_val    (commit_val)
  );

  inst_mem #(
    .opaq_bits   (opaq_bits),
    .mem_latency (mem_latency)
  ) u_inst_mem (
    .clk             (clk),
    .rst             (rst),
    .mem_req_val     (mem_req_val),
    .mem_req_op      (mem_req_op),
    .mem_req_addr    (mem_req_addr),
    .mem_req_opaque  (mem_req_opaque),
    .mem_req_len     (mem_req_len),
    .mem_req_data    (mem_req_data),
    .mem_req_rdy     (mem_req_rdy),
    .mem_resp_val    (mem_resp_val),
    .mem_resp_op     (mem_resp_op),
    .mem_resp_addr   (mem_resp_addr),
    .mem_resp_opaque (mem_resp_opaque),
    .mem_resp_len    (mem_resp_len),
    .mem_resp_data   (mem_resp_data),
    .mem_resp_rdy    (mem_resp_rdy)
  );

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
// Testbench for the fetch top level
// Clock, reset, decode and commit stimulus, reference model, checks, timeout

`default_nettype none
`timescale 1ns/1ps

module fetch_tb;

  localparam int seq_bits       = 3;
  localparam int num_seq        = 1 << seq_bits;
  localparam int lanes          = 2;
  localparam int latency        = 2;
  localparam int rom_depth      = 64;
  localparam int ref_bits       = 64 + seq_bits;
  localparam int timeout_cycles = 4000;

  logic                 clk;
  logic                 rst;
  logic                 d_val;
  logic [31:0]          d_pc;
  logic [31:0]          d_inst;
  logic [seq_bits-1:0]  d_seq_num;
  logic                 d_rdy;
  logic [lanes-1:0]     commit_val;

  logic [31:0]          tb_rom [rom_depth];
  logic [ref_bits-1:0]  expected;
  logic [31:0]          rnd;
  string                test_name;
  int                   deliv_cnt;
  int                   commit_total;
  int                   cycle_cnt;
  int                   start;
  int                   target;

  fetch_top #(
    .opaq_bits     (2),
    .seq_num_bits  (seq_bits),
    .reclaim_width (lanes),
    .mem_latency   (latency)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .d_val      (d_val),
    .d_pc       (d_pc),
    .d_inst     (d_inst),
    .d_seq_num  (d_seq_num),
    .d_rdy      (d_rdy),
    .commit_val (commit_val)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Expected {seq, pc, inst} of delivery k
  function automatic logic [ref_bits-1:0] ref_delivery(input int k);
    logic [31:0]         pc;
    logic [31:0]         inst;
    logic [seq_bits-1:0] seq;
    pc   = 32'h200 + 32'(4 * k);
    inst = tb_rom[(pc >> 2) % rom_depth];
    seq  = seq_bits'(k % num_seq);
    return {seq, pc, inst};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Retire up to want numbers but never more than outstanding
  task automatic drive_commit(input int want);
    int n;
    n = want;
    if (n > deliv_cnt - commit_total) begin
      n = deliv_cnt - commit_total;
    end
    if (n > lanes) begin
      n = lanes;
    end
    case (n)
      0:       commit_val = 2'b00;
      1:       commit_val = 2'b01;
      default: commit_val = 2'b11;
    endcase
    commit_total += n;
  endtask

  // ----------------------------------------
  // Clock, timeout, monitor
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, decode stream stopped making progress", cycle_cnt);
    $display("sim failed");
    $fatal(1, "run stopped on timeout");
  end

  // Every decode transfer against the reference
  always @(posedge clk) begin
    if (!rst && d_val && d_rdy) begin
      expected = ref_delivery(deliv_cnt);
      check_value("pc", expected[63:32], d_pc);
      check_value("inst", expected[31:0], d_inst);
      check_value("seq_num", 32'(expected[ref_bits-1:64]), 32'(d_seq_num));
      deliv_cnt++;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    rst          = 1'b1;
    d_rdy        = 1'b0;
    commit_val   = '0;
    rnd          = 32'hb81f;
    deliv_cnt    = 0;
    commit_total = 0;
    test_name    = "reset";
    $readmemh("hdl/inst_rom.hex", tb_rom);
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // Nothing reaches decode before the memory latency has passed
    repeat (latency + 1) begin
      @(posedge clk);
      check_value("d_val before first response", 0, 32'(d_val));
    end
    #1;

    // Full-rate stream with prompt commits across the ROM wrap
    test_name = "stream";
    d_rdy = 1'b1;
    while (deliv_cnt < 100) begin
      drive_commit(2);
      next_cycle();
    end
    commit_val = '0;

    // Drain, then hold all commits back
    test_name = "withheld";
    d_rdy = 1'b0;
    while (deliv_cnt != commit_total) begin
      drive_commit(2);
      next_cycle();
    end
    commit_val = '0;
    start = deliv_cnt;
    d_rdy = 1'b1;
    while (deliv_cnt < start + num_seq) next_cycle();
    repeat (20) begin
      @(posedge clk);
      check_value("d_val with all numbers held", 0, 32'(d_val));
    end
    #1;
    // One number back allows one more delivery
    drive_commit(1);
    next_cycle();
    commit_val = '0;
    while (deliv_cnt < start + num_seq + 1) next_cycle();
    repeat (10) next_cycle();
    check_value("deliveries after one commit", start + num_seq + 1, deliv_cnt);

    // Random decode stalls and commit widths
    test_name = "random";
    target = deliv_cnt + 200;
    while (deliv_cnt < target) begin
      rnd   = lcg_next(rnd);
      d_rdy = rnd[16];
      drive_commit(int'(rnd[19:18]));
      next_cycle();
    end
    commit_val = '0;

    // Exhaust numbers, then free two in one cycle
    test_name = "dual_commit";
    d_rdy = 1'b1;
    while (deliv_cnt - commit_total < num_seq) next_cycle();
    repeat (6) next_cycle();
    start = deliv_cnt;
    drive_commit(2);
    @(posedge clk);
    #1;
    commit_val = '0;
    @(posedge clk);
    check_value("first delivery after dual commit", 1, 32'(d_val));
    @(posedge clk);
    check_value("second delivery after dual commit", 1, 32'(d_val));
    @(posedge clk);
    check_value("d_val once numbers run out", 0, 32'(d_val));
    #1;
    check_value("deliveries after dual commit", start + 2, deliv_cnt);

    d_rdy = 1'b0;
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/mem_msg_pkg.sv
hdl/fetch_pkg.sv
hdl/seq_num_gen.sv
hdl/fetch_unit.sv
hdl/inst_mem.sv
hdl/fetch_top.sv
verif/fetch_tb.sv

// ==== hdl/inst_rom.hex ====
// One 32-bit instruction word per line in hex, word 0 at byte address 0x00
A5005C3F
A5015C3E
A5025C3D
A5035C3C
A5045C3B
A5055C3A
A5065C39
A5075C38
A5085C37
A5095C36
A50A5C35
A50B5C34
A50C5C33
A50D5C32
A50E5C31
A50F5C30
A5105C2F
A5115C2E
A5125C2D
A5135C2C
A5145C2B
A5155C2A
A5165C29
A5175C28
A5185C27
A5195C26
A51A5C25
A51B5C24
A51C5C23
A51D5C22
A51E5C21
A51F5C20
A5205C1F
A5215C1E
A5225C1D
A5235C1C
A5245C1B
A5255C1A
A5265C19
A5275C18
A5285C17
A5295C16
A52A5C15
A52B5C14
A52C5C13
A52D5C12
A52E5C11
A52F5C10
A5305C0F
A5315C0E
A5325C0D
A5335C0C
A5345C0B
A5355C0A
A5365C09
A5375C08
A5385C07
A5395C06
A53A5C05
A53B5C04
A53C5C03
A53D5C02
A53E5C01
A53F5C00
